//--- dma_node.f
+incdir+verif
verilog/dma_pkg.sv
verilog/dma_job_ctrl.sv
verilog/dma_read_engine.sv
verilog/dma_data_fifo.sv
verilog/dma_write_engine.sv
verilog/dma_scratchpad.sv
verilog/dma_node.sv
verif/tb_dma_node.sv

//--- Makefile
# Verilator build and run of the DMA node testbench
# sim fails unless the log holds the pass message

VERILATOR ?= verilator
TOP       ?= tb_dma_node
FILELIST  ?= dma_node.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_dma_tasks.svh
// testbench helpers for the DMA node
// host port access, job and response handshakes, the xorshift source
// and the reference memory; included inside the testbench module body

`ifndef TB_DMA_TASKS_SVH
`define TB_DMA_TASKS_SVH

// ----------------------------------------
// random words and reference memory
// ----------------------------------------

logic [31:0] rng_state = 32'd58;
dma_data_t   model_mem [MemWords];

// xorshift32
function automatic dma_data_t next_rand();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

function automatic dma_job_t make_job(input int src, input int dst, input int len);
  dma_job_t job;
  job.src_addr = dma_addr_t'(src);
  job.dst_addr = dma_addr_t'(dst);
  job.length   = dma_len_t'(len);
  return job;
endfunction

// zero length first, then both regions must end inside the memory
function automatic dma_status_e expected_status(input dma_job_t job);
  int src_end;
  int dst_end;
  src_end = int'(job.src_addr) + int'(job.length);
  dst_end = int'(job.dst_addr) + int'(job.length);
  if (job.length == '0) return DMA_ZERO_LEN;
  if ((src_end > MemWords) || (dst_end > MemWords)) return DMA_OUT_OF_RANGE;
  return DMA_OK;
endfunction

// word at src+i lands at dst+i
function automatic void apply_copy(input dma_job_t job);
  int i;
  for (i = 0; i < int'(job.length); i++) begin
    model_mem[int'(job.dst_addr) + i] = model_mem[int'(job.src_addr) + i];
  end
endfunction

// ----------------------------------------
// host port
// ----------------------------------------

task automatic host_write(input dma_addr_t addr, input dma_data_t data);
  @(posedge clk_i);
  host_we_i    <= 1'b1;
  host_addr_i  <= addr;
  host_wdata_i <= data;
  @(posedge clk_i);
  host_we_i <= 1'b0;
  model_mem[addr] = data;
endtask

task automatic host_read(input dma_addr_t addr, output dma_data_t data);
  @(posedge clk_i);
  host_re_i   <= 1'b1;
  host_addr_i <= addr;
  @(posedge clk_i);
  host_re_i <= 1'b0;
  // data registered on the edge above
  @(posedge clk_i);
  data = host_rdata_o;
endtask

// ----------------------------------------
// job and response handshakes
// ----------------------------------------

task automatic raise_job(input dma_job_t job);
  @(posedge clk_i);
  job_i     <= job;
  job_req_i <= 1'b1;
endtask

task automatic complete_job_handshake();
  int n;
  n = 0;
  do begin
    @(posedge clk_i);
    n++;
  end while (!job_ack_o && (n < WaitLimit));
  if (!job_ack_o) stop_on_timeout("job_ack_o to rise");
  job_req_i <= 1'b0;
  n = 0;
  do begin
    @(posedge clk_i);
    n++;
  end while (job_ack_o && (n < WaitLimit));
  if (job_ack_o) stop_on_timeout("job_ack_o to fall");
endtask

task automatic wait_response(output dma_rsp_t rsp);
  int n;
  n = 0;
  do begin
    @(posedge clk_i);
    n++;
    check_value("busy_o", busy_o, 1);
  end while (!rsp_req_o && (n < WaitLimit));
  if (!rsp_req_o) stop_on_timeout("rsp_req_o to rise");
  rsp = rsp_o;
endtask

// node must stay busy until the ack is released
task automatic ack_response(input int delay);
  int n;
  repeat (delay) begin
    @(posedge clk_i);
    check_value("rsp_req_o", rsp_req_o, 1);
    check_value("busy_o", busy_o, 1);
  end
  rsp_ack_i <= 1'b1;
  n = 0;
  do begin
    @(posedge clk_i);
    n++;
    check_value("busy_o", busy_o, 1);
  end while (rsp_req_o && (n < WaitLimit));
  if (rsp_req_o) stop_on_timeout("rsp_req_o to fall");
  rsp_ack_i <= 1'b0;
  n = 0;
  do begin
    @(posedge clk_i);
    n++;
  end while (busy_o && (n < WaitLimit));
  if (busy_o) stop_on_timeout("busy_o to fall");
endtask

`endif

//--- verif/tb_dma_node.sv
`timescale 1ns/1ps
// testbench for the DMA node
// host port, copy and rejection tests against a reference memory, plus a
// handshake monitor; prints one line per test and a closing count line

module tb_dma_node;

  import dma_pkg::*;

  localparam int unsigned FifoDepth = FifoDepthDefault;
  localparam int MemWords  = 2 ** AddrWidth;
  localparam int WaitLimit = 2000;

  logic      clk_i;
  logic      reset_i;
  dma_job_t  job_i;
  logic      job_req_i;
  logic      job_ack_o;
  dma_rsp_t  rsp_o;
  logic      rsp_req_o;
  logic      rsp_ack_i;
  logic      host_we_i;
  logic      host_re_i;
  dma_addr_t host_addr_i;
  dma_data_t host_wdata_i;
  dma_data_t host_rdata_o;
  logic      busy_o;

  int errors = 0;
  int errors_at_start = 0;
  int tests_run = 0;
  int tests_failed = 0;

  dma_node #(
    .FifoDepth ( FifoDepth )
  ) uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // checks and reporting
  // ----------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout after %0d cycles waiting for %s", WaitLimit, what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d failed checks", tests_run, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  `include "tb_dma_tasks.svh"

  task automatic check_memory();
    dma_data_t got;
    int        a;
    for (a = 0; a < MemWords; a++) begin
      host_read(dma_addr_t'(a), got);
      check_value($sformatf("host_rdata_o @ 0x%02h", a), got, model_mem[a]);
    end
  endtask

  // status and count from the job rules, then the model takes the copy
  task automatic check_response(input dma_job_t job, input dma_rsp_t rsp);
    dma_status_e exp_status;
    exp_status = expected_status(job);
    check_value("rsp_o.status", rsp.status, exp_status);
    check_value("rsp_o.words_done", rsp.words_done,
                (exp_status == DMA_OK) ? job.length : '0);
    if (exp_status == DMA_OK) apply_copy(job);
  endtask

  task automatic run_job(input dma_job_t job, input int ack_delay);
    dma_rsp_t rsp;
    raise_job(job);
    complete_job_handshake();
    wait_response(rsp);
    check_response(job, rsp);
    ack_response(ack_delay);
  endtask

  // ----------------------------------------
  // handshake monitor
  // ----------------------------------------

  logic     ack_q = 1'b0;
  logic     req_q = 1'b0;
  dma_rsp_t rsp_q = '0;

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (job_ack_o && !ack_q) begin
        assert (job_req_i) else begin
          $display("job_ack_o rose while job_req_i was low");
          errors++;
        end
      end
      // a held response blocks the next job
      assert (!(job_ack_o && (rsp_req_o || rsp_ack_i))) else begin
        $display("job_ack_o was high during a response handshake");
        errors++;
      end
      if (rsp_req_o && req_q) begin
        assert (rsp_o == rsp_q) else begin
          $display("CHECK FAILED rsp_o: changed from 0x%0h to 0x%0h", rsp_q, rsp_o);
          errors++;
        end
      end
    end
    ack_q <= job_ack_o;
    req_q <= rsp_req_o;
    rsp_q <= rsp_o;
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin
    dma_job_t  job_a;
    dma_job_t  job_b;
    dma_rsp_t  rsp;
    dma_data_t got;
    int        a;
    reset_i      = 1'b1;
    job_i        = '0;
    job_req_i    = 1'b0;
    rsp_ack_i    = 1'b0;
    host_we_i    = 1'b0;
    host_re_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);
    check_value("job_ack_o", job_ack_o, 0);
    check_value("rsp_req_o", rsp_req_o, 0);
    check_value("busy_o", busy_o, 0);
    check_value("rsp_o", rsp_o, 0);
    end_test("reset values");

    for (a = 0; a < MemWords; a++) host_write(dma_addr_t'(a), next_rand());
    check_memory();
    end_test("host write and readback");

    run_job(make_job(10, 200, 1), 0);
    host_read(dma_addr_t'(200), got);
    check_value("host_rdata_o @ 0xc8", got, model_mem[200]);
    end_test("one word copy");

    for (a = 32; a < 32 + 3 * FifoDepth; a++) host_write(dma_addr_t'(a), next_rand());
    run_job(make_job(32, 128, 3 * FifoDepth), 6);
    check_memory();
    end_test("long copy with delayed ack");

    run_job(make_job(5, 6, 0), 0);
    check_memory();
    end_test("zero length job");

    run_job(make_job(0, 250, 10), 2);
    check_memory();
    end_test("destination out of range");

    job_a = make_job(64, 96, 4);
    job_b = make_job(160, 192, 5);
    raise_job(job_a);
    complete_job_handshake();
    wait_response(rsp);
    check_response(job_a, rsp);
    // second request waits behind the unacknowledged response
    raise_job(job_b);
    repeat (6) begin
      @(posedge clk_i);
      check_value("job_ack_o", job_ack_o, 0);
    end
    ack_response(0);
    complete_job_handshake();
    wait_response(rsp);
    check_response(job_b, rsp);
    ack_response(0);
    check_memory();
    end_test("job held behind response");

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verilog/dma_node.sv
`timescale 1ns/1ps
// DMA endpoint node, top level
// job controller, read engine, data FIFO, write engine and scratchpad;
// jobs and responses use four-phase handshakes, the host port works while idle

module dma_node #(
  parameter int unsigned FifoDepth = dma_pkg::FifoDepthDefault
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  dma_pkg::dma_job_t  job_i,
  input  logic               job_req_i,
  output logic               job_ack_o,
  output dma_pkg::dma_rsp_t  rsp_o,
  output logic               rsp_req_o,
  input  logic               rsp_ack_i,
  input  logic               host_we_i,
  input  logic               host_re_i,
  input  dma_pkg::dma_addr_t host_addr_i,
  input  dma_pkg::dma_data_t host_wdata_i,
  output dma_pkg::dma_data_t host_rdata_o,
  output logic               busy_o
);

  import dma_pkg::*;

  localparam int unsigned CountWidth = $clog2(FifoDepth + 1);

  // ----------------------------------------
  // controller to engines
  // ----------------------------------------

  logic      rd_start;
  logic      wr_start;
  dma_addr_t src_addr;
  dma_addr_t dst_addr;
  dma_len_t  length;
  logic      wr_done;

  // ----------------------------------------
  // data path
  // ----------------------------------------

  logic                  rd_en;
  dma_addr_t             rd_addr;
  dma_data_t             rd_data;
  dma_data_t             push_data;
  logic                  push_valid;
  logic                  push_ready;
  dma_data_t             pop_data;
  logic                  pop_valid;
  logic                  pop_ready;
  logic [CountWidth-1:0] fifo_free;
  logic                  wr_en;
  dma_addr_t             wr_addr;
  dma_data_t             wr_data;

  dma_job_ctrl i_job_ctrl (
    .clk_i      ( clk_i     ),
    .reset_i    ( reset_i   ),
    .job_i      ( job_i     ),
    .job_req_i  ( job_req_i ),
    .job_ack_o  ( job_ack_o ),
    .rsp_o      ( rsp_o     ),
    .rsp_req_o  ( rsp_req_o ),
    .rsp_ack_i  ( rsp_ack_i ),
    .rd_start_o ( rd_start  ),
    .wr_start_o ( wr_start  ),
    .src_addr_o ( src_addr  ),
    .dst_addr_o ( dst_addr  ),
    .length_o   ( length    ),
    .wr_done_i  ( wr_done   ),
    .busy_o     ( busy_o    )
  );

  dma_read_engine #(
    .FifoDepth ( FifoDepth )
  ) i_read_engine (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .start_i      ( rd_start   ),
    .src_addr_i   ( src_addr   ),
    .length_i     ( length     ),
    .free_i       ( fifo_free  ),
    .rd_en_o      ( rd_en      ),
    .rd_addr_o    ( rd_addr    ),
    .rd_data_i    ( rd_data    ),
    .push_data_o  ( push_data  ),
    .push_valid_o ( push_valid ),
    .push_ready_i ( push_ready )
  );

  dma_data_fifo #(
    .FifoDepth ( FifoDepth )
  ) i_data_fifo (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .push_data_i  ( push_data  ),
    .push_valid_i ( push_valid ),
    .push_ready_o ( push_ready ),
    .pop_data_o   ( pop_data   ),
    .pop_valid_o  ( pop_valid  ),
    .pop_ready_i  ( pop_ready  ),
    .free_o       ( fifo_free  )
  );

  dma_write_engine i_write_engine (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .start_i     ( wr_start  ),
    .dst_addr_i  ( dst_addr  ),
    .length_i    ( length    ),
    .pop_data_i  ( pop_data  ),
    .pop_valid_i ( pop_valid ),
    .pop_ready_o ( pop_ready ),
    .wr_en_o     ( wr_en     ),
    .wr_addr_o   ( wr_addr   ),
    .wr_data_o   ( wr_data   ),
    .done_o      ( wr_done   )
  );

  dma_scratchpad i_scratchpad (
    .clk_i        ( clk_i        ),
    .busy_i       ( busy_o       ),
    .rd_en_i      ( rd_en        ),
    .rd_addr_i    ( rd_addr      ),
    .rd_data_o    ( rd_data      ),
    .wr_en_i      ( wr_en        ),
    .wr_addr_i    ( wr_addr      ),
    .wr_data_i    ( wr_data      ),
    .host_we_i    ( host_we_i    ),
    .host_re_i    ( host_re_i    ),
    .host_addr_i  ( host_addr_i  ),
    .host_wdata_i ( host_wdata_i ),
    .host_rdata_o ( host_rdata_o )
  );

endmodule

//--- verilog/dma_scratchpad.sv
`timescale 1ns/1ps
// on-node scratchpad, one read port and one write port
// while busy the DMA engines own both ports, otherwise the host port
// does; reads have one cycle of latency for both owners

module dma_scratchpad (
  input  logic               clk_i,
  input  logic               busy_i,
  input  logic               rd_en_i,
  input  dma_pkg::dma_addr_t rd_addr_i,
  output dma_pkg::dma_data_t rd_data_o,
  input  logic               wr_en_i,
  input  dma_pkg::dma_addr_t wr_addr_i,
  input  dma_pkg::dma_data_t wr_data_i,
  input  logic               host_we_i,
  input  logic               host_re_i,
  input  dma_pkg::dma_addr_t host_addr_i,
  input  dma_pkg::dma_data_t host_wdata_i,
  output dma_pkg::dma_data_t host_rdata_o
);

  import dma_pkg::*;

  localparam int unsigned NumWords = 2 ** AddrWidth;

  dma_data_t mem_q [NumWords];
  logic      a_en;
  dma_addr_t a_addr;
  dma_data_t a_data_q;
  logic      b_en;
  dma_addr_t b_addr;
  dma_data_t b_data;

  // ----------------------------------------
  // port ownership
  // ----------------------------------------

  always_comb begin
    if (busy_i) begin
      a_en   = rd_en_i;
      a_addr = rd_addr_i;
      b_en   = wr_en_i;
      b_addr = wr_addr_i;
      b_data = wr_data_i;
    end else begin
      a_en   = host_re_i;
      a_addr = host_addr_i;
      b_en   = host_we_i;
      b_addr = host_addr_i;
      b_data = host_wdata_i;
    end
  end

  // port A, registered read that holds its value between reads
  always_ff @(posedge clk_i) begin
    if (a_en) a_data_q <= mem_q[a_addr];
  end

  // port B
  always_ff @(posedge clk_i) begin
    if (b_en) mem_q[b_addr] <= b_data;
  end

  assign rd_data_o    = a_data_q;
  assign host_rdata_o = a_data_q;

endmodule

//--- verilog/dma_write_engine.sv
`timescale 1ns/1ps
// write engine, consumer side of the copy pipeline
// drains the data FIFO into consecutive destination addresses on
// scratchpad port B and pulses done with the last write

module dma_write_engine (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               start_i,
  input  dma_pkg::dma_addr_t dst_addr_i,
  input  dma_pkg::dma_len_t  length_i,
  input  dma_pkg::dma_data_t pop_data_i,
  input  logic               pop_valid_i,
  output logic               pop_ready_o,
  output logic               wr_en_o,
  output dma_pkg::dma_addr_t wr_addr_o,
  output dma_pkg::dma_data_t wr_data_o,
  output logic               done_o
);

  import dma_pkg::*;

  dma_addr_t addr_q;
  dma_len_t  remain_q;

  // ----------------------------------------
  // one pop and one write per cycle
  // ----------------------------------------

  assign pop_ready_o = (remain_q != '0);
  assign wr_en_o     = pop_valid_i && pop_ready_o;
  assign wr_addr_o   = addr_q;
  assign wr_data_o   = pop_data_i;

  // last word goes out this cycle
  assign done_o = wr_en_o && (remain_q == dma_len_t'(1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      remain_q <= '0;
    end else if (start_i) begin
      remain_q <= length_i;
    end else if (wr_en_o) begin
      remain_q <= remain_q - 1'b1;
    end
  end

  // destination pointer, payload only
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= dst_addr_i;
    end else if (wr_en_o) begin
      addr_q <= addr_q + 1'b1;
    end
  end

endmodule

//--- verilog/dma_data_fifo.sv
`timescale 1ns/1ps
// data FIFO between the read and write engines
// circular buffer with valid/ready on both sides; the free slot count
// feeds the read engine's credit check

module dma_data_fifo #(
  parameter int unsigned FifoDepth = dma_pkg::FifoDepthDefault
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  dma_pkg::dma_data_t             push_data_i,
  input  logic                           push_valid_i,
  output logic                           push_ready_o,
  output dma_pkg::dma_data_t             pop_data_o,
  output logic                           pop_valid_o,
  input  logic                           pop_ready_i,
  output logic [$clog2(FifoDepth+1)-1:0] free_o
);

  import dma_pkg::*;

  localparam int unsigned PtrWidth   = $clog2(FifoDepth);
  localparam int unsigned CountWidth = $clog2(FifoDepth + 1);

  typedef logic [PtrWidth-1:0]   ptr_t;
  typedef logic [CountWidth-1:0] count_t;

  localparam ptr_t   LastSlot = ptr_t'(FifoDepth - 1);
  localparam count_t Depth    = count_t'(FifoDepth);

  dma_data_t mem_q [FifoDepth];
  ptr_t      wptr_q;
  ptr_t      rptr_q;
  count_t    count_q;
  logic      push_fire;
  logic      pop_fire;

  assign push_ready_o = (count_q != Depth);
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rptr_q];
  assign free_o       = Depth - count_q;
  assign push_fire    = push_valid_i && push_ready_o;
  assign pop_fire     = pop_valid_o && pop_ready_i;

  // ----------------------------------------
  // pointers and occupancy
  // ----------------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push_fire) wptr_q <= (wptr_q == LastSlot) ? '0 : wptr_q + 1'b1;
      if (pop_fire) rptr_q <= (rptr_q == LastSlot) ? '0 : rptr_q + 1'b1;
      if (push_fire && !pop_fire) begin
        count_q <= count_q + 1'b1;
      end else if (pop_fire && !push_fire) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_fire) mem_q[wptr_q] <= push_data_i;
  end

endmodule

//--- verilog/dma_read_engine.sv
`timescale 1ns/1ps
// read engine, producer side of the copy pipeline
// reads source words from scratchpad port A and pushes them into the
// data FIFO, issuing a read only when a FIFO slot is left for it

module dma_read_engine #(
  parameter int unsigned FifoDepth = dma_pkg::FifoDepthDefault
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           start_i,
  input  dma_pkg::dma_addr_t             src_addr_i,
  input  dma_pkg::dma_len_t              length_i,
  input  logic [$clog2(FifoDepth+1)-1:0] free_i,
  output logic                           rd_en_o,
  output dma_pkg::dma_addr_t             rd_addr_o,
  input  dma_pkg::dma_data_t             rd_data_i,
  output dma_pkg::dma_data_t             push_data_o,
  output logic                           push_valid_o,
  input  logic                           push_ready_i
);

  import dma_pkg::*;

  localparam int unsigned CountWidth = $clog2(FifoDepth + 1);

  dma_addr_t             addr_q;
  dma_len_t              remain_q;
  logic                  pending_q;
  logic [CountWidth-1:0] inflight_q;
  logic                  push_fire;

  // credit check against reads not yet pushed
  assign rd_en_o   = (remain_q != '0) && (free_i > inflight_q);
  assign rd_addr_o = addr_q;

  // read data arrives one cycle after the issue
  assign push_valid_o = pending_q;
  assign push_data_o  = rd_data_i;
  assign push_fire    = push_valid_o && push_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      remain_q   <= '0;
      pending_q  <= 1'b0;
      inflight_q <= '0;
    end else begin
      pending_q <= rd_en_o || (pending_q && !push_ready_i);
      if (start_i) begin
        remain_q <= length_i;
      end else if (rd_en_o) begin
        remain_q <= remain_q - 1'b1;
      end
      case ({rd_en_o, push_fire})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q <= src_addr_i;
    end else if (rd_en_o) begin
      addr_q <= addr_q + 1'b1;
    end
  end

endmodule

//--- verilog/dma_job_ctrl.sv
`timescale 1ns/1ps
// job controller of the DMA node
// takes a job over a four-phase handshake, checks its range, starts
// both engines and returns the response over a second four-phase handshake

module dma_job_ctrl (
  input  logic               clk_i,
  input  logic               reset_i,
  input  dma_pkg::dma_job_t  job_i,
  input  logic               job_req_i,
  output logic               job_ack_o,
  output dma_pkg::dma_rsp_t  rsp_o,
  output logic               rsp_req_o,
  input  logic               rsp_ack_i,
  output logic               rd_start_o,
  output logic               wr_start_o,
  output dma_pkg::dma_addr_t src_addr_o,
  output dma_pkg::dma_addr_t dst_addr_o,
  output dma_pkg::dma_len_t  length_o,
  input  logic               wr_done_i,
  output logic               busy_o
);

  import dma_pkg::*;

  // end address of a region, one bit wider than a length
  typedef logic [LenWidth:0] end_t;

  localparam end_t MemWords = end_t'(2 ** AddrWidth);

  typedef enum logic [2:0] {
    IDLE,
    ACK,
    CHECK,
    RUN,
    RESP,
    RESP_WAIT
  } state_e;

  state_e      state_q;
  state_e      state_d;
  dma_job_t    job_q;
  dma_rsp_t    rsp_q;
  dma_status_e check_status;
  end_t        src_end;
  end_t        dst_end;
  logic        start;

  // ----------------------------------------
  // range check on the captured job
  // ----------------------------------------

  always_comb begin
    src_end = end_t'(job_q.src_addr) + end_t'(job_q.length);
    dst_end = end_t'(job_q.dst_addr) + end_t'(job_q.length);
    if (job_q.length == '0) begin
      check_status = DMA_ZERO_LEN;
    end else if ((src_end > MemWords) || (dst_end > MemWords)) begin
      check_status = DMA_OUT_OF_RANGE;
    end else begin
      check_status = DMA_OK;
    end
  end

  // both engines start in the same cycle
  assign start      = (state_q == CHECK) && (check_status == DMA_OK);
  assign rd_start_o = start;
  assign wr_start_o = start;
  assign src_addr_o = job_q.src_addr;
  assign dst_addr_o = job_q.dst_addr;
  assign length_o   = job_q.length;

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (job_req_i) state_d = ACK;
      ACK:       if (!job_req_i) state_d = CHECK;
      CHECK:     state_d = (check_status == DMA_OK) ? RUN : RESP;
      RUN:       if (wr_done_i) state_d = RESP;
      RESP:      if (rsp_ack_i) state_d = RESP_WAIT;
      // no new job until the host has released its ack
      RESP_WAIT: if (!rsp_ack_i) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      rsp_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == CHECK) begin
        rsp_q.status     <= check_status;
        rsp_q.words_done <= (check_status == DMA_OK) ? job_q.length : '0;
      end
    end
  end

  // job is held stable by the host while the request is high
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && job_req_i) begin
      job_q <= job_i;
    end
  end

  assign job_ack_o = (state_q == ACK);
  assign rsp_req_o = (state_q == RESP);
  assign rsp_o     = rsp_q;
  assign busy_o    = (state_q != IDLE);

endmodule

//--- verilog/dma_pkg.sv
// shared widths, word types and channel structs of the DMA node
// imported by every RTL module and by the testbench

package dma_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------

  localparam int unsigned DataWidth = 32;
  // 256-word scratchpad
  localparam int unsigned AddrWidth = 8;
  // one extra bit so a full-memory copy fits
  localparam int unsigned LenWidth = AddrWidth + 1;
  localparam int unsigned FifoDepthDefault = 8;

  typedef logic [DataWidth-1:0] dma_data_t;
  typedef logic [AddrWidth-1:0] dma_addr_t;
  typedef logic [LenWidth-1:0]  dma_len_t;

  // ----------------------------------------
  // job and response channels
  // ----------------------------------------

  typedef enum logic [1:0] {
    DMA_OK           = 2'd0,
    DMA_ZERO_LEN     = 2'd1,
    DMA_OUT_OF_RANGE = 2'd2
  } dma_status_e;

  // 8 + 8 + 9 bits
  typedef struct packed {
    dma_addr_t src_addr;
    dma_addr_t dst_addr;
    dma_len_t  length;
  } dma_job_t;

  // words_done is zero for a rejected job
  typedef struct packed {
    dma_status_e status;
    dma_len_t    words_done;
  } dma_rsp_t;

endpackage
